/* Makefile */
TOP = datapathTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: build
	./obj_dir/V$(TOP) | awk '{ print } /All tests passed!/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f
	verilator --lint-only --top-module busDatapath -f project.f

clean:
	rm -rf obj_dir

/* project.f */
+incdir+verilog
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/stepCounter.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/aluUnit.sv
verilog/busUnit.sv
verilog/busDatapath.sv
test/datapathTb.sv

/* test/datapathTb.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module datapathTb;
    import isaPkg::*;

    localparam int MemWords = 128;
    localparam int TimeoutCycles = 60;
    localparam int StoreBase = 200;

    typedef struct packed {
        opcode_e op;
        word_t   a;
        word_t   b;
        word_t   expected;
        word_t   addr;
    } row_t;

    logic  clk;
    logic  rst;
    word_t memRdata;
    word_t memAddr;
    word_t memWdata;
    logic  memRead;
    logic  memWrite;

    word_t       mem [MemWords];
    row_t        rows [$];
    int          progLen = 0;
    int unsigned lcgState = 20841;
    int          errors = 0;
    int          checks = 0;
    int          cycle = 0;
    int          reads = 0;
    int          lastRead = 0;

    busDatapath dut0 (
        .clk      (clk),
        .rst      (rst),
        .memRdata (memRdata),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRead  (memRead),
        .memWrite (memWrite)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Instruction memory. Addresses past the program read as zero, an
    // illegal opcode that the control unit runs as idle steps.
    always @(posedge clk) begin
        #1;
        if (memRead && memAddr < MemWords) begin
            memRdata <= mem[memAddr[6:0]];
        end else begin
            memRdata <= '0;
        end
    end

    task automatic checkValue(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0d ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic word_t signExt(input logic [`IMM_W-1:0] v);
        return {{(`WORD_W - `IMM_W){v[`IMM_W-1]}}, v};
    endfunction

    // Operands reach registers through ldi, so they must fit the immediate.
    function automatic word_t randImm();
        logic [31:0] r;
        r = nextRandom();
        return signExt(r[22:8]);
    endfunction

    function automatic word_t modelResult(input opcode_e op, input word_t a, input word_t b);
        logic [4:0] n;
        word_t      r;
        n = b[4:0];
        case (op)
            opLdi:   r = a;
            opAdd:   r = a + b;
            opSub:   r = a - b;
            opAnd:   r = a & b;
            opOr:    r = a | b;
            opShr:   r = a >> n;
            opShra:  r = (a >> n) | (a[31] ? ~(32'hFFFF_FFFF >> n) : 32'd0);
            opShl:   r = a << n;
            opRor:   r = (n == 0) ? a : (a >> n) | (a << (6'd32 - n));
            opRol:   r = (n == 0) ? a : (a << n) | (a >> (6'd32 - n));
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic word_t encode(input opcode_e op, input int ra, input int rb,
                                     input int rc, input word_t imm);
        instr_t ins;
        ins.opcode = op;
        ins.ra = regIdx_t'(ra);
        ins.rb = regIdx_t'(rb);
        ins.rc = regIdx_t'(rc);
        ins.imm = imm[`IMM_W-1:0];
        return word_t'(ins);
    endfunction

    task automatic addRow(input opcode_e op, input word_t a, input word_t b,
                          input bit randA, input bit randB);
        row_t r;
        r.op = op;
        r.a = randA ? randImm() : a;
        r.b = randB ? randImm() : b;
        r.expected = modelResult(op, r.a, r.b);
        r.addr = StoreBase + rows.size();
        rows.push_back(r);
    endtask

    task automatic emit(input word_t w);
        mem[progLen] = w;
        progLen++;
    endtask

    // Each row gets its own three registers, so register 0 is used too.
    task automatic loadProgram();
        int ra;
        int rb;
        int rc;
        foreach (mem[i]) begin
            mem[i] = '0;
        end
        foreach (rows[i]) begin
            ra = i % 16;
            rb = (i + 5) % 16;
            rc = (i + 11) % 16;
            if (rows[i].op == opLdi) begin
                emit(encode(opLdi, ra, 0, 0, rows[i].a));
            end else begin
                emit(encode(opLdi, rb, 0, 0, rows[i].a));
                emit(encode(opLdi, rc, 0, 0, rows[i].b));
                emit(encode(rows[i].op, ra, rb, rc, '0));
            end
            emit(encode(opSt, ra, 0, 0, rows[i].addr));
        end
    endtask

    task automatic waitForWrite(output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < TimeoutCycles) begin
            @(negedge clk);
            seen = memWrite;
            n++;
        end
    endtask

    // Reads start in the second cycle after reset and come every six cycles
    // from consecutive addresses. A store writes in T5.
    always @(negedge clk) begin
        if (rst) begin
            checkValue("memRead", word_t'(memRead), '0);
            checkValue("memWrite", word_t'(memWrite), '0);
        end else begin
            cycle++;
            if (cycle == 1) begin
                checkValue("memRead", word_t'(memRead), '0);
                checkValue("memWrite", word_t'(memWrite), '0);
            end
            if (memRead) begin
                if (reads == 0) begin
                    checkValue("first memRead cycle", cycle, 2);
                end else begin
                    checkValue("cycles between memRead", cycle - lastRead, 6);
                end
                checkValue("memAddr on fetch", memAddr, reads);
                reads++;
                lastRead = cycle;
            end
            if (memWrite) begin
                checkValue("cycles from memRead to memWrite", cycle - lastRead, 4);
            end
        end
    end

    initial begin
        opcode_e shiftOps [3];
        int      amounts [3];
        bit      seen;
        bit      timedOut;
        int      rowErrors;
        int      done;
        rst = 1'b1;
        memRdata = '0;
        timedOut = 1'b0;
        done = 0;
        shiftOps = '{opShr, opShra, opShl};
        amounts = '{0, 1, 31};

        addRow(opLdi, 1234, 0, 1'b0, 1'b0);
        addRow(opLdi, -4321, 0, 1'b0, 1'b0);
        addRow(opAdd, 0, 0, 1'b1, 1'b1);
        addRow(opSub, 0, 0, 1'b1, 1'b1);
        addRow(opSub, 5, 9, 1'b0, 1'b0);
        addRow(opAnd, 0, 0, 1'b1, 1'b1);
        addRow(opOr, 0, 0, 1'b1, 1'b1);
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k < 3; k++) begin
                addRow(shiftOps[s], -12345, amounts[k], 1'b0, 1'b0);
            end
        end
        addRow(opShra, -32, 2, 1'b0, 1'b0);
        addRow(opShr, -12345, 34, 1'b0, 1'b0);
        addRow(opRor, 0, 0, 1'b1, 1'b1);
        addRow(opRol, 0, 0, 1'b1, 1'b1);
        addRow(opRor, 0, 0, 1'b1, 1'b0);
        addRow(opRol, 0, 0, 1'b1, 1'b0);
        loadProgram();

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < rows.size() && !timedOut; i++) begin
            rowErrors = errors;
            waitForWrite(seen);
            if (!seen) begin
                $display("Row %0d (%s): the store never wrote to memory within %0d cycles",
                         i, rows[i].op.name(), TimeoutCycles);
                errors++;
                timedOut = 1'b1;
            end else begin
                checkValue("memAddr", memAddr, rows[i].addr);
                checkValue("memWdata", memWdata, rows[i].expected);
                $display("Row %0d %s: %s", i, rows[i].op.name(),
                         (errors == rowErrors) ? "ok" : "FAILED");
                done++;
            end
        end

        $display("%0d of %0d rows done, %0d checks, %0d errors",
                 done, rows.size(), checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog/aluUnit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module aluUnit (
    input  logic            clk,
    input  logic            rst,
    input  isaPkg::word_t   bus,
    input  logic            yIn,
    input  logic            zIn,
    input  isaPkg::opcode_e op,
    output isaPkg::word_t   z
);
    import isaPkg::*;

    word_t                  y;
    word_t                  result;
    logic [`SHAMT_W-1:0]    shamt;
    logic [2*`WORD_W-1:0]   rotRight;
    logic [2*`WORD_W-1:0]   rotLeft;

    // The bus supplies the second operand and the shift amount.
    assign shamt = bus[`SHAMT_W-1:0];

    // Rotates shift a doubled copy of Y, so an amount of zero needs no
    // special case.
    assign rotRight = {y, y} >> shamt;
    assign rotLeft  = {y, y} << shamt;

    always_comb begin
        case (op)
            opAdd:   result = y + bus;
            opSub:   result = y - bus;
            opAnd:   result = y & bus;
            opOr:    result = y | bus;
            opShr:   result = y >> shamt;
            opShra:  result = word_t'($signed(y) >>> shamt);
            opShl:   result = y << shamt;
            opRor:   result = rotRight[`WORD_W-1:0];
            opRol:   result = rotLeft[2*`WORD_W-1:`WORD_W];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            y <= '0;
            z <= '0;
        end else begin
            if (yIn) begin
                y <= bus;
            end
            if (zIn) begin
                z <= result;
            end
        end
    end

    // Y has to hold its operand for the whole cycle in which Z loads.
    yBeforeZ: assert property (@(posedge clk) disable iff (rst)
        !(yIn && zIn));

endmodule

/* verilog/busDatapath.sv */
`timescale 1ns/1ps

module busDatapath (
    input  logic          clk,
    input  logic          rst,
    input  isaPkg::word_t memRdata,
    output isaPkg::word_t memAddr,
    output isaPkg::word_t memWdata,
    output logic          memRead,
    output logic          memWrite
);
    import isaPkg::*;
    import ctrlPkg::*;

    step_e  step;
    ctrl_t  ctrl;
    instr_t instr;
    word_t  bus;
    word_t  regData;
    word_t  z;

    stepCounter stepCounter0 (
        .clk  (clk),
        .rst  (rst),
        .step (step)
    );

    controlUnit controlUnit0 (
        .clk   (clk),
        .rst   (rst),
        .step  (step),
        .instr (instr),
        .ctrl  (ctrl)
    );

    registerFile registerFile0 (
        .clk       (clk),
        .rst       (rst),
        .readIdx   (ctrl.readIdx),
        .writeIdx  (ctrl.writeIdx),
        .writeEn   (ctrl.regWrite),
        .writeData (bus),
        .readData  (regData)
    );

    aluUnit aluUnit0 (
        .clk (clk),
        .rst (rst),
        .bus (bus),
        .yIn (ctrl.yIn),
        .zIn (ctrl.zIn),
        .op  (ctrl.aluOp),
        .z   (z)
    );

    busUnit busUnit0 (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .regData  (regData),
        .z        (z),
        .memRdata (memRdata),
        .bus      (bus),
        .instr    (instr),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRead  (memRead),
        .memWrite (memWrite)
    );

endmodule

/* verilog/busUnit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module busUnit (
    input  logic           clk,
    input  logic           rst,
    input  ctrlPkg::ctrl_t ctrl,
    input  isaPkg::word_t  regData,
    input  isaPkg::word_t  z,
    input  isaPkg::word_t  memRdata,
    output isaPkg::word_t  bus,
    output isaPkg::instr_t instr,
    output isaPkg::word_t  memAddr,
    output isaPkg::word_t  memWdata,
    output logic           memRead,
    output logic           memWrite
);
    import isaPkg::*;
    import ctrlPkg::*;

    word_t  pc;
    word_t  mar;
    word_t  mdr;
    instr_t ir;

    always_comb begin
        case (ctrl.busSrc)
            srcReg:  bus = regData;
            srcZ:    bus = z;
            srcMdr:  bus = mdr;
            srcPc:   bus = pc;
            srcImm:  bus = {{(`WORD_W - `IMM_W){ir.imm[`IMM_W-1]}}, ir.imm};
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc  <= '0;
            mar <= '0;
            mdr <= '0;
            ir  <= '0;
        end else begin
            if (ctrl.incPc) pc <= pc + 1'b1;
            if (ctrl.marIn) mar <= bus;
            if (ctrl.mdrIn) mdr <= ctrl.mdrFromMem ? memRdata : bus;
            if (ctrl.irIn)  ir <= instr_t'(bus);
        end
    end

    assign instr    = ir;
    assign memAddr  = mar;
    assign memWdata = mdr;
    assign memRead  = ctrl.memRead;
    assign memWrite = ctrl.memWrite;

    // MAR must capture the old PC in the step that increments it.
    incWithPcOut: assert property (@(posedge clk) disable iff (rst)
        ctrl.incPc |-> ctrl.pcOut && ctrl.busSrc == srcPc);

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic            clk,
    input  logic            rst,
    input  ctrlPkg::step_e  step,
    input  isaPkg::instr_t  instr,
    output ctrlPkg::ctrl_t  ctrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    typedef enum logic [1:0] {
        phFetch, phDecode, phExec, phIdle
    } phase_e;

    phase_e phase;
    phase_e phaseNext;

    function automatic logic isAluOp(input opcode_e op);
        return op inside {opAdd, opSub, opAnd, opOr, opShr, opShra, opShl, opRor, opRol};
    endfunction

    // Fetch covers T0 and T1, decode is T2 while IR loads, and execute
    // starts in T3 once IR holds the new instruction.
    always_comb begin
        phaseNext = phase;
        unique case (phase)
            phFetch:  if (step == T1) phaseNext = phDecode;
            phDecode: phaseNext = phExec;
            phExec: begin
                if (step == T5) begin
                    phaseNext = phFetch;
                end else if (step == T3 && !(isAluOp(instr.opcode) || instr.opcode == opSt)) begin
                    // ldi finishes in T3; an unknown opcode does nothing at all.
                    phaseNext = phIdle;
                end
            end
            phIdle:   if (step == T5) phaseNext = phFetch;
            default:  phaseNext = phFetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= phFetch;
        end else begin
            phase <= phaseNext;
        end
    end

    always_comb begin
        ctrl = '0;
        if (!rst) begin
            unique case (phase)
                phFetch: begin
                    if (step == T0) begin
                        ctrl.busSrc = srcPc;
                        ctrl.pcOut  = 1'b1;
                        ctrl.marIn  = 1'b1;
                        ctrl.incPc  = 1'b1;
                    end else begin
                        ctrl.memRead    = 1'b1;
                        ctrl.mdrIn      = 1'b1;
                        ctrl.mdrFromMem = 1'b1;
                    end
                end
                phDecode: begin
                    ctrl.busSrc = srcMdr;
                    ctrl.irIn   = 1'b1;
                end
                phExec: begin
                    if (isAluOp(instr.opcode)) begin
                        case (step)
                            T3: begin
                                ctrl.busSrc  = srcReg;
                                ctrl.readIdx = instr.rb;
                                ctrl.yIn     = 1'b1;
                            end
                            T4: begin
                                ctrl.busSrc  = srcReg;
                                ctrl.readIdx = instr.rc;
                                ctrl.aluOp   = instr.opcode;
                                ctrl.zIn     = 1'b1;
                            end
                            T5: begin
                                ctrl.busSrc   = srcZ;
                                ctrl.regWrite = 1'b1;
                                ctrl.writeIdx = instr.ra;
                            end
                            default: ;
                        endcase
                    end else if (instr.opcode == opLdi) begin
                        if (step == T3) begin
                            ctrl.busSrc   = srcImm;
                            ctrl.regWrite = 1'b1;
                            ctrl.writeIdx = instr.ra;
                        end
                    end else if (instr.opcode == opSt) begin
                        case (step)
                            T3: begin
                                ctrl.busSrc = srcImm;
                                ctrl.marIn  = 1'b1;
                            end
                            T4: begin
                                ctrl.busSrc  = srcReg;
                                ctrl.readIdx = instr.ra;
                                ctrl.mdrIn   = 1'b1;
                            end
                            T5: ctrl.memWrite = 1'b1;
                            default: ;
                        endcase
                    end
                end
                default: ;
            endcase
        end
    end

    noReadWrite: assert property (@(posedge clk) disable iff (rst)
        !(ctrl.memRead && ctrl.memWrite));

    writeInT5: assert property (@(posedge clk) disable iff (rst)
        ctrl.memWrite |-> step == T5);

    // The phase register must stay aligned with the step counter.
    fetchAtT0: assert property (@(posedge clk) disable iff (rst)
        step == T0 |-> phase == phFetch);

endmodule

/* verilog/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data word carried on the bus and held in every datapath register.
`define WORD_W 32

// Register index width, giving sixteen general registers.
`define REG_IDX_W 4
`define NUM_REGS 16

// Instruction field widths. Opcode, three register fields and the
// immediate fill one word exactly.
`define OPCODE_W 5
`define IMM_W 15

// Only the low bits of the shift operand count as the amount.
`define SHAMT_W 5

`endif

/* verilog/ctrlPkg.sv */
package ctrlPkg;

    typedef enum logic [2:0] {
        T0, T1, T2, T3, T4, T5
    } step_e;

    // Sources that can drive the shared bus; srcNone leaves it at zero.
    typedef enum logic [2:0] {
        srcNone, srcReg, srcZ, srcMdr, srcPc, srcImm
    } busSrc_e;

    typedef struct packed {
        busSrc_e         busSrc;
        isaPkg::regIdx_t readIdx;
        logic            regWrite;
        isaPkg::regIdx_t writeIdx;
        logic            yIn;
        logic            zIn;
        isaPkg::opcode_e aluOp;
        logic            pcOut;
        logic            incPc;
        logic            marIn;
        logic            mdrIn;
        logic            mdrFromMem;
        logic            irIn;
        logic            memRead;
        logic            memWrite;
    } ctrl_t;

endpackage

/* verilog/isaPkg.sv */
`include "cpu_defines.svh"

package isaPkg;

    typedef logic [`WORD_W-1:0] word_t;

    typedef logic [`REG_IDX_W-1:0] regIdx_t;

    typedef logic [`IMM_W-1:0] imm_t;

    // Encodings follow the Mini SRC numbering; ld and the later
    // instructions are not part of this datapath.
    typedef enum logic [`OPCODE_W-1:0] {
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opRor  = 5'd7,
        opRol  = 5'd8,
        opShr  = 5'd9,
        opShra = 5'd10,
        opShl  = 5'd11
    } opcode_e;

    // Instruction word layout, opcode in the top bits.
    typedef struct packed {
        opcode_e opcode;
        regIdx_t ra;
        regIdx_t rb;
        regIdx_t rc;
        imm_t    imm;
    } instr_t;

endpackage

/* verilog/registerFile.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module registerFile (
    input  logic            clk,
    input  logic            rst,
    input  isaPkg::regIdx_t readIdx,
    input  isaPkg::regIdx_t writeIdx,
    input  logic            writeEn,
    input  isaPkg::word_t   writeData,
    output isaPkg::word_t   readData
);
    import isaPkg::*;

    word_t regs [`NUM_REGS];

    // Reads are combinational so the selected register reaches the bus
    // in the same step.
    assign readData = regs[readIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeIdx] <= writeData;
        end
    end

endmodule

/* verilog/stepCounter.sv */
`timescale 1ns/1ps

module stepCounter (
    input  logic          clk,
    input  logic          rst,
    output ctrlPkg::step_e step
);
    import ctrlPkg::*;

    step_e stepNext;

    always_comb begin
        if (step == T5) begin
            stepNext = T0;
        end else begin
            stepNext = step_e'(step + 3'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= T0;
        end else begin
            step <= stepNext;
        end
    end

    // Codes 6 and 7 are never reached.
    stepInRange: assert property (@(posedge clk) disable iff (rst)
        step inside {T0, T1, T2, T3, T4, T5});

endmodule
